// ==== Bender.yml ====
package:
  name: corr

sources:
  - include_dirs:
      - src
    files:
      - src/corr_pkg.sv
      - src/slot_counter.sv
      - src/corr_sequencer.sv
      - src/beat_fifo.sv
      - src/corr_datapath.sv
      - src/corr_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tb_corr_top.sv

// ==== project.f ====
+incdir+src
src/corr_pkg.sv
src/slot_counter.sv
src/corr_sequencer.sv
src/beat_fifo.sv
src/corr_datapath.sv
src/corr_top.sv
sim/tb_corr_top.sv

// ==== sim/corr_vectors.txt ====
# I then four input samples, lane 0 first
# O then dest code and four expected sums, lane 0 first
I 5 -32 1 31
O 0 5 -32 1 31
O 1 -5 32 -1 -31
I -3 -32 2 -32
O 0 -8 0 1 -63
O 1 8 0 -1 63
I 31 -32 3 31
O 0 39 -32 2 94
O 1 -29 -32 0 -32
I 31 -32 4 -32
O 0 2 -64 4 -64
O 1 -8 0 0 0
I 31 31 -32 -7
O 0 28 -1 -31 24
O 1 34 -63 37 38
I -32 0 31 20
O 0 -1 -95 70 26
O 1 63 31 -62 -90
I -32 12 -32 -15
O 0 62 11 -91 -74
O 1 0 51 27 60
I 7 -1 31 31
O 0 38 18 62 59
O 1 -102 -18 0 -19
I 31 31 -32 -32
O 0 -40 44 -64 -58
O 1 -24 -20 0 28
I 31 -32 -32 31
O 0 -25 -52 -1 79
O 1 39 50 63 -17
I -32 -32 31 31
O 0 -25 30 62 -1
O 1 87 32 -126 -63
I 31 31 -32 -32
O 0 125 62 -127 -64
O 1 -63 -126 63 126

// ==== sim/tb_corr_top.sv ====
// testbench for corr_top with vector file, credit-driven sender and randomly delayed consumer
`include "corr_cfg.svh"

module tb_corr_top;

  import corr_pkg::*;

  localparam int          CLK_PERIOD  = 4;
  localparam int          DRIVE_DELAY = 1;
  localparam int          RESET_CYCLES = 5;
  localparam logic [15:0] LFSR_SEED   = 16'd30468;
  // x^16 + x^14 + x^13 + x^11 + 1
  localparam logic [15:0] LFSR_MASK   = 16'hB400;

  logic      clk;
  logic      reset;
  logic      in_valid;
  in_beat_t  in_beat;
  logic      out_credit;
  logic      in_credit;
  logic      out_valid;
  out_beat_t out_beat;

  // vectors from the data file
  in_beat_t  in_q[$];
  out_beat_t exp_q[$];
  int        num_in;
  logic      loaded;

  // sender and consumer model state
  logic [15:0] lfsr_state;
  int          next_in;
  int          sender_credits;
  int          outstanding;
  int          credit_delay_q[$];

  corr_top u_dut (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .out_credit (out_credit),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_beat   (out_beat)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input integer expected, input integer actual);
    if (expected !== actual) begin
      $display("CHECK FAILED at time %0t: %s expected %0d actual %0d",
               $time, name, expected, actual);
      stop_on_error();
    end
  endtask

  // galois step, shift right and fold the mask on a one
  function automatic logic [15:0] next_lfsr(input logic [15:0] state);
    next_lfsr = state[0] ? ((state >> 1) ^ LFSR_MASK) : (state >> 1);
  endfunction

  // one random bit per step
  task automatic draw_bit(output logic b);
    b = lfsr_state[0];
    lfsr_state = next_lfsr(lfsr_state);
  endtask

  task automatic read_vectors();
    int               fd;
    int               n;
    int               v[5];
    byte              tag;
    logic [8*128-1:0] rest;
    in_beat_t         ib;
    out_beat_t        ob;
    fd = $fopen("sim/corr_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/corr_vectors.txt for reading");
      stop_on_error();
    end
    while (1) begin
      n = $fscanf(fd, " %c", tag);
      if (n != 1) begin
        break;
      end
      case (tag)
        "#": n = $fgets(rest, fd);
        "I": begin
          n = $fscanf(fd, "%d %d %d %d", v[0], v[1], v[2], v[3]);
          if (n != 4) begin
            $display("malformed input line in the vector file");
            stop_on_error();
          end
          for (int i = 0; i < `CORR_LANES; i++) begin
            ib.samples[i] = sample_t'(v[i]);
          end
          in_q.push_back(ib);
        end
        "O": begin
          n = $fscanf(fd, "%d %d %d %d %d", v[0], v[1], v[2], v[3], v[4]);
          if (n != 5) begin
            $display("malformed output line in the vector file");
            stop_on_error();
          end
          ob.dest = code_idx_t'(v[0]);
          for (int i = 0; i < `CORR_LANES; i++) begin
            ob.sums[i] = sum_t'(v[i + 1]);
          end
          exp_q.push_back(ob);
        end
        default: begin
          $display("unknown line tag in the vector file");
          stop_on_error();
        end
      endcase
    end
    $fclose(fd);
    num_in = in_q.size();
    // two output beats per input beat
    if (num_in == 0 || exp_q.size() != num_in * `CORR_NUM_CODES) begin
      $display("vector file does not hold two output lines per input line");
      stop_on_error();
    end
  endtask

  // compare one DUT beat with the next expected line
  task automatic check_beat();
    out_beat_t e;
    if (exp_q.size() == 0) begin
      $display("output beat at time %0t arrived with no expected beat left", $time);
      stop_on_error();
    end
    e = exp_q.pop_front();
    check_value("out_beat.dest", e.dest, out_beat.dest);
    for (int i = 0; i < `CORR_LANES; i++) begin
      check_value($sformatf("out_beat.sums[%0d]", i), e.sums[i], out_beat.sums[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // one clock of sender and consumer
  ////////////////////////////////////////////////////////////////////////

  task automatic run_cycle();
    logic b;
    int   delay;
    @(posedge clk);
    #(DRIVE_DELAY);
    // quiet outputs until the first beat goes out
    if (next_in == 0) begin
      check_value("out_valid", 0, out_valid);
      check_value("in_credit", 0, in_credit);
    end
    if (in_credit) begin
      if (sender_credits >= `CORR_FIFO_DEPTH) begin
        $display("input credit returned beyond the buffer depth at time %0t", $time);
        stop_on_error();
      end
      sender_credits++;
    end
    if (out_valid) begin
      check_beat();
      outstanding++;
      if (outstanding > `CORR_OUT_CREDITS) begin
        $display("output beat sent without a credit at time %0t", $time);
        stop_on_error();
      end
      // credit comes back 0 to 7 cycles later
      delay = 0;
      repeat (3) begin
        draw_bit(b);
        delay = delay * 2 + int'(b);
      end
      credit_delay_q.push_back(delay);
    end
    // consumer returns credits in order
    out_credit = 1'b0;
    if (credit_delay_q.size() > 0) begin
      if (credit_delay_q[0] == 0) begin
        void'(credit_delay_q.pop_front());
        out_credit = 1'b1;
        outstanding--;
      end else begin
        credit_delay_q[0]--;
      end
    end
    // sender only while holding a credit
    in_valid = 1'b0;
    if (next_in < num_in && sender_credits > 0) begin
      draw_bit(b);
      if (b) begin
        in_valid = 1'b1;
        in_beat = in_q[next_in];
        next_in++;
        sender_credits--;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////

  initial begin
    reset = 1'b1;
    in_valid = 1'b0;
    in_beat = '0;
    out_credit = 1'b0;
    loaded = 1'b0;
    lfsr_state = LFSR_SEED;
    next_in = 0;
    sender_credits = `CORR_FIFO_DEPTH;
    outstanding = 0;
    read_vectors();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    reset = 1'b0;
    while (next_in < num_in || exp_q.size() > 0 || credit_delay_q.size() > 0) begin
      run_cycle();
    end
    // idle tail, nothing more may come out
    repeat (20) run_cycle();
    check_value("sender_credits", `CORR_FIFO_DEPTH, sender_credits);
    $display("test passed");
    $finish;
  end

  // budget of 40 cycles per input beat plus margin
  initial begin
    wait (loaded === 1'b1);
    repeat (num_in * 40 + 200) @(posedge clk);
    $display("timeout with %0d of %0d input beats sent and %0d output beats missing",
             next_in, num_in, exp_q.size());
    stop_on_error();
  end

endmodule

// ==== src/beat_fifo.sv ====
// input beat FIFO with registered read and a credit pulse per pop
`include "corr_cfg.svh"

module beat_fifo (
  input  logic               clk,
  input  logic               reset,
  input  logic               push,
  input  corr_pkg::in_beat_t din,
  input  logic               pop,
  output corr_pkg::in_beat_t head,
  output logic               not_empty,
  output logic               credit
);

  import corr_pkg::*;

  localparam int DEPTH = `CORR_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  in_beat_t          mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;

  assign not_empty = (count != '0);

  // pointers, fill level and credit return
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count  <= count + CNT_W'(push) - CNT_W'(pop);
      // freed entry goes back to the sender
      credit <= pop;
    end
  end

  // storage and read register
  // head holds the popped beat until the next pop
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
    if (pop) begin
      head <= mem[rd_ptr];
    end
  end

  // sender pushed without a credit
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> count < CNT_W'(DEPTH));

  // sequencer popped an empty buffer
  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    pop |-> not_empty);

endmodule

// ==== src/corr_cfg.svh ====
// correlator configuration macros for lanes, widths, codes, input buffer depth and output credits
`ifndef CORR_CFG_SVH
`define CORR_CFG_SVH

// lanes per input beat, one sample each
`define CORR_LANES 4

// signed sample width on the input side
`define CORR_SAMPLE_W 6

// signed sum width, room for four full-scale taps
`define CORR_SUM_W 10

// number of binary codes and taps per code
`define CORR_NUM_CODES 2
`define CORR_CODE_LEN 4

// code bits packed by code, code 0 in the low nibble
// bit k of a code scales the sample delayed by k beats, 1 means +1
`define CORR_CODES 8'h6D

// input buffer entries, also the sender's starting credit count
`define CORR_FIFO_DEPTH 4

// output beats allowed in flight before the consumer returns credit
`define CORR_OUT_CREDITS 2

`endif

// ==== src/corr_datapath.sv ====
// correlator datapath with sign-select adder chain, slot-indexed partial sums and output beat
`include "corr_cfg.svh"

module corr_datapath (
  input  logic                clk,
  input  logic                reset,
  input  corr_pkg::in_beat_t  head,
  input  logic                load,
  input  logic                accumulate,
  input  corr_pkg::slot_t     slot,
  input  logic                last_lane,
  output logic                out_valid,
  output corr_pkg::out_beat_t out_beat
);

  import corr_pkg::*;

  localparam int LEN       = `CORR_CODE_LEN;
  localparam int NUM_SLOTS = `CORR_LANES * `CORR_NUM_CODES;
  localparam logic [`CORR_NUM_CODES*LEN-1:0] CODES = `CORR_CODES;

  // beat under processing
  in_beat_t beat_q;

  // partial sums per chain stage and slot
  // last stage goes straight to the output register
  sum_t part_q [LEN-1][NUM_SLOTS];

  sample_t         lane_sample;
  sum_t            sample_ext;
  logic [LEN-1:0]  code_bits;
  sum_t            term [LEN];
  sum_t            acc [LEN];

  //////////////////////////////////////////////////////////////////////
  // slot select
  //////////////////////////////////////////////////////////////////////

  assign lane_sample = beat_q.samples[slot.lane];
  // sign extend to sum width
  assign sample_ext  = sum_t'(lane_sample);
  assign code_bits   = CODES[slot.code*LEN +: LEN];

  //////////////////////////////////////////////////////////////////////
  // adder chain
  //////////////////////////////////////////////////////////////////////

  // chain stage j adds today's sample
  // that term reaches the output LEN-1-j beats later
  // so it is scaled by code bit LEN-1-j
  for (genvar j = 0; j < LEN; j++) begin : g_chain
    assign term[j] = code_bits[LEN-1-j] ? sample_ext : -sample_ext;
    if (j == 0) begin : g_first
      // oldest tap starts from zero
      assign acc[j] = term[j];
    end else begin : g_rest
      // read of stage j-1 before this edge's write
      assign acc[j] = part_q[j-1][slot] + term[j];
    end
  end

  // history starts at zero after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int j = 0; j < LEN - 1; j++) begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
          part_q[j][s] <= '0;
        end
      end
    end else if (accumulate) begin
      for (int j = 0; j < LEN - 1; j++) begin
        part_q[j][slot] <= acc[j];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // beat latch and output assembly
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load) begin
      beat_q <= head;
    end
    if (accumulate) begin
      // completed sum lands in its lane
      out_beat.sums[slot.lane] <= acc[LEN-1];
      if (last_lane) begin
        out_beat.dest <= slot.code;
      end
    end
  end

  // one pulse per code, after its last lane
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= accumulate && last_lane;
    end
  end

endmodule

// ==== src/corr_pkg.sv ====
// shared correlator types for samples, sums, lane and code indices, slots and beats
`include "corr_cfg.svh"

package corr_pkg;

  //////////////////////////////////////////////////////////////////////
  // scalar types
  //////////////////////////////////////////////////////////////////////

  // one input sample, two's complement
  typedef logic signed [`CORR_SAMPLE_W-1:0] sample_t;

  // one correlation sum
  typedef logic signed [`CORR_SUM_W-1:0] sum_t;

  // lane and code numbers
  typedef logic [$clog2(`CORR_LANES)-1:0] lane_idx_t;
  typedef logic [$clog2(`CORR_NUM_CODES)-1:0] code_idx_t;

  //////////////////////////////////////////////////////////////////////
  // beats and slots
  //////////////////////////////////////////////////////////////////////

  // input beat, lane 0 in the low bits
  typedef struct packed {
    sample_t [`CORR_LANES-1:0] samples;
  } in_beat_t;

  // output beat for one code
  typedef struct packed {
    code_idx_t               dest;
    sum_t [`CORR_LANES-1:0]  sums;
  } out_beat_t;

  // processing slot, lane is the fast digit so it sits low
  // the packed value doubles as the partial-sum address
  typedef struct packed {
    code_idx_t code;
    lane_idx_t lane;
  } slot_t;

endpackage

// ==== src/corr_sequencer.sv ====
// correlator sequencer FSM with input pop, slot stepping and output credit tracking
`include "corr_cfg.svh"

module corr_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic not_empty,
  input  logic last_lane,
  input  logic last_slot,
  input  logic out_credit,
  output logic pop,
  output logic load,
  output logic step,
  output logic clear,
  output logic accumulate
);

  localparam int CREDIT_W = $clog2(`CORR_OUT_CREDITS + 1);

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    WAIT_CREDIT,
    RUN
  } state_t;

  state_t state;
  state_t state_next;

  logic [CREDIT_W-1:0] credits;
  logic [CREDIT_W-1:0] credit_next;
  logic                consume;
  logic                credit_ok;

  //////////////////////////////////////////////////////////////////////
  // output credit counter
  //////////////////////////////////////////////////////////////////////

  // one credit spent per code, at its last lane
  assign consume = (state == RUN) && last_lane;

  // count as it will stand next cycle
  assign credit_next = credits + CREDIT_W'(out_credit) - CREDIT_W'(consume);
  assign credit_ok   = (credit_next != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CREDIT_W'(`CORR_OUT_CREDITS);
    end else begin
      credits <= credit_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (not_empty) begin
          state_next = LOAD;
        end
      end
      LOAD: begin
        // first code needs a credit before lane 0
        state_next = credit_ok ? RUN : WAIT_CREDIT;
      end
      WAIT_CREDIT: begin
        if (credit_ok) begin
          state_next = RUN;
        end
      end
      RUN: begin
        if (last_slot) begin
          state_next = IDLE;
        end else if (last_lane && !credit_ok) begin
          // code boundary with nothing left to spend
          state_next = WAIT_CREDIT;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  // pop in IDLE, the buffer's read register shows the beat during LOAD
  assign pop        = (state == IDLE) && not_empty;
  assign load       = (state == LOAD);
  assign clear      = (state == LOAD);
  assign accumulate = (state == RUN);
  assign step       = accumulate;

  // consumer never returns more credit than beats it received
  a_credit_max: assert property (@(posedge clk) disable iff (reset)
    out_credit && !consume |-> credits < CREDIT_W'(`CORR_OUT_CREDITS));

  // credit checked before lane 0 is still held at the last lane
  a_credit_min: assert property (@(posedge clk) disable iff (reset)
    consume |-> credits != '0);

endmodule

// ==== src/corr_top.sv ====
// correlator top level tying input FIFO, sequencer, slot counter and datapath together

module corr_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                in_valid,
  input  corr_pkg::in_beat_t  in_beat,
  input  logic                out_credit,
  output logic                in_credit,
  output logic                out_valid,
  output corr_pkg::out_beat_t out_beat
);

  import corr_pkg::*;

  // buffer to sequencer and datapath
  in_beat_t head;
  logic     not_empty;
  logic     pop;

  // sequencer controls
  logic     load;
  logic     step;
  logic     clear;
  logic     accumulate;

  // slot state
  slot_t    slot;
  logic     last_lane;
  logic     last_slot;

  // input buffer, sender pushes only while holding credit
  beat_fifo u_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (in_valid),
    .din       (in_beat),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty),
    .credit    (in_credit)
  );

  corr_sequencer u_seq (
    .clk        (clk),
    .reset      (reset),
    .not_empty  (not_empty),
    .last_lane  (last_lane),
    .last_slot  (last_slot),
    .out_credit (out_credit),
    .pop        (pop),
    .load       (load),
    .step       (step),
    .clear      (clear),
    .accumulate (accumulate)
  );

  slot_counter u_slot (
    .clk       (clk),
    .reset     (reset),
    .step      (step),
    .clear     (clear),
    .slot      (slot),
    .last_lane (last_lane),
    .last_slot (last_slot)
  );

  corr_datapath u_dp (
    .clk        (clk),
    .reset      (reset),
    .head       (head),
    .load       (load),
    .accumulate (accumulate),
    .slot       (slot),
    .last_lane  (last_lane),
    .out_valid  (out_valid),
    .out_beat   (out_beat)
  );

endmodule

// ==== src/slot_counter.sv ====
// slot counter stepping lane then code, with last-lane and last-slot flags
`include "corr_cfg.svh"

module slot_counter (
  input  logic             clk,
  input  logic             reset,
  input  logic             step,
  input  logic             clear,
  output corr_pkg::slot_t  slot,
  output logic             last_lane,
  output logic             last_slot
);

  import corr_pkg::*;

  // flags decoded from the registered slot only
  assign last_lane = (slot.lane == lane_idx_t'(`CORR_LANES - 1));
  assign last_slot = last_lane && (slot.code == code_idx_t'(`CORR_NUM_CODES - 1));

  // lane advances every step
  // code advances when the lane wraps
  always_ff @(posedge clk) begin
    if (reset) begin
      slot <= '0;
    end else if (clear) begin
      // start of a new input beat
      slot <= '0;
    end else if (step) begin
      if (last_slot) begin
        slot <= '0;
      end else if (last_lane) begin
        slot.lane <= '0;
        slot.code <= slot.code + 1'b1;
      end else begin
        slot.lane <= slot.lane + 1'b1;
      end
    end
  end

endmodule
